// ==== list.f ====
src/ir_pkg.sv
src/ir_space_timer.sv
src/ir_frame_fsm.sv
src/ir_frame_shifter.sv
src/ir_wb_regs.sv
src/ir_decoder_top.sv
verif/ir_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the IR decoder testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module ir_decoder_tb -f list.f -o ir_decoder_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ir_decoder_sim > sim.log 2>&1
tail -n 5 sim.log

grep -q "Simulation PASSED" sim.log && echo "run.sh: test passed" \
    || { echo "run.sh: test failed"; exit 1; }

// ==== src/ir_decoder_top.sv ====
module ir_decoder_top #(
    parameter int unsigned CLOCK_FREQ_HZ = 25_000_000
) (
    input  logic              CLK_I,
    input  logic              rst_n,
    input  ir_pkg::ir_addr_t  adr,
    input  ir_pkg::ir_byte_t  dat_w,
    input  logic              stb,
    input  logic              we,
    output logic              ack,
    output ir_pkg::ir_byte_t  dat_r,
    input  logic              ir_in
);

    logic                 space_done;
    ir_pkg::space_class_t space_class;
    logic                 stop_seen;
    logic                 shift_en;
    logic                 shift_bit;
    logic                 clear_bits;
    logic                 frame_done;
    logic                 repeat_hit;
    logic                 bits_full;
    logic                 frame_valid;
    ir_pkg::ir_frame_t    frame;

    // raw line to classified spaces
    ir_space_timer #(
        .CLOCK_FREQ_HZ (CLOCK_FREQ_HZ)
    ) timer_i (
        .CLK_I       (CLK_I),
        .rst_n       (rst_n),
        .ir_in       (ir_in),
        .space_done  (space_done),
        .space_class (space_class),
        .stop_seen   (stop_seen)
    );

    ir_frame_fsm fsm_i (
        .CLK_I       (CLK_I),
        .rst_n       (rst_n),
        .space_done  (space_done),
        .space_class (space_class),
        .stop_seen   (stop_seen),
        .bits_full   (bits_full),
        .frame_valid (frame_valid),
        .shift_en    (shift_en),
        .shift_bit   (shift_bit),
        .clear_bits  (clear_bits),
        .frame_done  (frame_done),
        .repeat_hit  (repeat_hit)
    );

    ir_frame_shifter shifter_i (
        .CLK_I      (CLK_I),
        .rst_n      (rst_n),
        .shift_en   (shift_en),
        .shift_bit  (shift_bit),
        .clear_bits (clear_bits),
        .frame_done (frame_done),
        .bits_full  (bits_full),
        .frame      (frame)
    );

    // host side
    ir_wb_regs regs_i (
        .CLK_I       (CLK_I),
        .rst_n       (rst_n),
        .adr         (adr),
        .dat_w       (dat_w),
        .stb         (stb),
        .we          (we),
        .ack         (ack),
        .dat_r       (dat_r),
        .frame       (frame),
        .frame_done  (frame_done),
        .repeat_hit  (repeat_hit),
        .frame_valid (frame_valid)
    );

endmodule

// ==== src/ir_frame_fsm.sv ====
module ir_frame_fsm (
    input  logic                  CLK_I,
    input  logic                  rst_n,
    input  logic                  space_done,
    input  ir_pkg::space_class_t  space_class,
    input  logic                  stop_seen,
    input  logic                  bits_full,
    input  logic                  frame_valid,
    output logic                  shift_en,
    output logic                  shift_bit,
    output logic                  clear_bits,
    output logic                  frame_done,
    output logic                  repeat_hit
);

    ir_pkg::frame_state_t state;
    logic                 is_bit;
    logic                 is_leader;
    logic                 is_repeat;

    assign is_bit    = (space_class == ir_pkg::SPACE_ZERO) ||
                       (space_class == ir_pkg::SPACE_ONE);
    assign is_leader = (space_class == ir_pkg::SPACE_LEADER);
    assign is_repeat = (space_class == ir_pkg::SPACE_REPEAT);

    // bits_full already counts the bit being shifted this cycle,
    // so the last shift and frame_done line up
    assign frame_done = (state == ir_pkg::ST_BITS) && bits_full &&
                        !clear_bits;  // old count is still 32 until the clear lands

    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            state <= ir_pkg::ST_IDLE;
        end else begin
            case (state)
                ir_pkg::ST_IDLE: begin
                    if (space_done && is_leader) begin
                        state <= ir_pkg::ST_BITS;
                    end
                end
                ir_pkg::ST_BITS: begin
                    if (frame_done) begin
                        state <= ir_pkg::ST_HOLD;
                    end else if (stop_seen) begin
                        state <= ir_pkg::ST_IDLE;    // frame cut short
                    end else if (space_done && !is_bit) begin
                        state <= ir_pkg::ST_IDLE;    // noise, repeat or stray leader
                    end
                end
                ir_pkg::ST_HOLD: begin
                    // wait for the line to settle before the next frame
                    if (stop_seen || (space_done && is_leader)) begin
                        state <= ir_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= ir_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // strobes follow space_done by one cycle
    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            shift_en   <= 1'b0;
            shift_bit  <= 1'b0;
            clear_bits <= 1'b0;
            repeat_hit <= 1'b0;
        end else begin
            shift_en   <= (state == ir_pkg::ST_BITS) && space_done && is_bit;
            shift_bit  <= (space_class == ir_pkg::SPACE_ONE);
            clear_bits <= (state == ir_pkg::ST_IDLE) && space_done && is_leader;
            // a repeat only counts while the host still has a frame
            repeat_hit <= (state == ir_pkg::ST_IDLE) && space_done && is_repeat &&
                          frame_valid;
        end
    end

    // a frame completes only right after its 32nd bit space
    assert property (@(posedge CLK_I) disable iff (!rst_n)
        frame_done |-> bits_full && shift_en && $past(space_done));

endmodule

// ==== src/ir_frame_shifter.sv ====
module ir_frame_shifter (
    input  logic               CLK_I,
    input  logic               rst_n,
    input  logic               shift_en,
    input  logic               shift_bit,
    input  logic               clear_bits,
    input  logic               frame_done,
    output logic               bits_full,
    output ir_pkg::ir_frame_t  frame
);

    ir_pkg::ir_frame_t  shreg;       // working register
    ir_pkg::ir_frame_t  shreg_next;
    ir_pkg::ir_bitcnt_t bit_cnt;

    assign shreg_next = {shreg[30:0], shift_bit};

    // full once the bit arriving now lands
    assign bits_full = (bit_cnt == 6'd32) || (shift_en && bit_cnt == 6'd31);

    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (clear_bits) begin
            bit_cnt <= '0;
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK_I) begin
        if (shift_en) begin
            shreg <= shreg_next;  // first bit ends up in bit 31
        end
    end

    // buffer the host reads, stable until the next frame
    always_ff @(posedge CLK_I) begin
        if (frame_done) begin
            frame <= shift_en ? shreg_next : shreg;
        end
    end

    // the FSM must stop shifting once 32 bits are in
    assert property (@(posedge CLK_I) disable iff (!rst_n)
        bit_cnt <= 6'd32);

endmodule

// ==== src/ir_pkg.sv ====
package ir_pkg;

    // data carried between the blocks
    typedef logic [31:0] ir_frame_t;   // one NEC frame, first bit in bit 31
    typedef logic [7:0]  ir_byte_t;    // wishbone data byte
    typedef logic [2:0]  ir_addr_t;    // wishbone register address
    typedef logic [5:0]  ir_bitcnt_t;  // received bits, 0 to 32

    // classification of one space (line high) by its length
    typedef enum logic [2:0] {
        SPACE_NONE,    // too short for anything
        SPACE_ZERO,
        SPACE_ONE,
        SPACE_REPEAT,
        SPACE_LEADER,
        SPACE_STOP     // line stayed high past the stop time
    } space_class_t;

    // frame assembly states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BITS,
        ST_HOLD
    } frame_state_t;

    // register map
    localparam ir_addr_t REG_BYTE0  = 3'd0;  // frame bits 31:24
    localparam ir_addr_t REG_BYTE1  = 3'd1;
    localparam ir_addr_t REG_BYTE2  = 3'd2;
    localparam ir_addr_t REG_BYTE3  = 3'd3;  // frame bits 7:0
    localparam ir_addr_t REG_STATUS = 3'd4;

    localparam int unsigned STATUS_VALID_BIT  = 0;
    localparam int unsigned STATUS_REPEAT_BIT = 1;

    // lower bounds of each space class, in microseconds
    localparam int unsigned T_ZERO_US   = 400;   // nominal 560
    localparam int unsigned T_ONE_US    = 1400;  // nominal 1690
    localparam int unsigned T_REPEAT_US = 2000;  // nominal 2250
    localparam int unsigned T_LEADER_US = 4000;  // nominal 4500
    localparam int unsigned T_STOP_US   = 8000;

endpackage

// ==== src/ir_space_timer.sv ====
module ir_space_timer #(
    parameter int unsigned CLOCK_FREQ_HZ = 25_000_000
) (
    input  logic                  CLK_I,
    input  logic                  rst_n,
    input  logic                  ir_in,
    output logic                  space_done,
    output ir_pkg::space_class_t  space_class,
    output logic                  stop_seen
);

    localparam int unsigned CYC_PER_US = CLOCK_FREQ_HZ / 1_000_000;
    localparam int unsigned PRESC_W    = (CYC_PER_US > 1) ? $clog2(CYC_PER_US) : 1;
    localparam int unsigned CNT_W      = $clog2(ir_pkg::T_STOP_US + 1);

    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(CYC_PER_US - 1);
    localparam logic [CNT_W-1:0]   CNT_MAX    = CNT_W'(ir_pkg::T_STOP_US);

    logic [2:0]           sync;       // sync[2] is the oldest sample
    logic                 level;      // filtered line level
    logic [PRESC_W-1:0]   presc;
    logic                 us_tick;
    logic [CNT_W-1:0]     space_cnt;  // microseconds spent high, saturating
    ir_pkg::space_class_t class_now;

    // the receiver idles high, so start as if a long space is running
    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            sync  <= 3'b111;
            level <= 1'b1;
        end else begin
            sync <= {sync[1:0], ir_in};
            if (sync == 3'b111) begin
                level <= 1'b1;
            end else if (sync == 3'b000) begin
                level <= 1'b0;
            end
        end
    end

    // free running microsecond prescaler
    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (presc == PRESC_LAST) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    assign us_tick = (presc == PRESC_LAST);

    // largest threshold not above the current count
    always_comb begin
        if (space_cnt >= CNT_W'(ir_pkg::T_STOP_US)) begin
            class_now = ir_pkg::SPACE_STOP;
        end else if (space_cnt >= CNT_W'(ir_pkg::T_LEADER_US)) begin
            class_now = ir_pkg::SPACE_LEADER;
        end else if (space_cnt >= CNT_W'(ir_pkg::T_REPEAT_US)) begin
            class_now = ir_pkg::SPACE_REPEAT;
        end else if (space_cnt >= CNT_W'(ir_pkg::T_ONE_US)) begin
            class_now = ir_pkg::SPACE_ONE;
        end else if (space_cnt >= CNT_W'(ir_pkg::T_ZERO_US)) begin
            class_now = ir_pkg::SPACE_ZERO;
        end else begin
            class_now = ir_pkg::SPACE_NONE;
        end
    end

    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            space_cnt   <= CNT_MAX;
            space_done  <= 1'b0;
            space_class <= ir_pkg::SPACE_NONE;
            stop_seen   <= 1'b0;
        end else begin
            space_done <= 1'b0;
            stop_seen  <= 1'b0;
            if (level && sync == 3'b000) begin       // filtered falling edge ends the space
                space_done  <= 1'b1;
                space_class <= class_now;
            end else if (!level && sync == 3'b111) begin
                space_cnt <= '0;                     // new space starts
            end else if (level && us_tick && space_cnt != CNT_MAX) begin
                space_cnt <= space_cnt + 1'b1;
                if (space_cnt == CNT_MAX - 1'b1) begin
                    stop_seen <= 1'b1;               // fires once per space
                end
            end
        end
    end

    // the frame FSM handles at most one event per cycle
    assert property (@(posedge CLK_I) disable iff (!rst_n)
        !(space_done && stop_seen));

endmodule

// ==== src/ir_wb_regs.sv ====
module ir_wb_regs (
    input  logic               CLK_I,
    input  logic               rst_n,
    input  ir_pkg::ir_addr_t   adr,
    input  ir_pkg::ir_byte_t   dat_w,
    input  logic               stb,
    input  logic               we,
    output logic               ack,
    output ir_pkg::ir_byte_t   dat_r,
    input  ir_pkg::ir_frame_t  frame,
    input  logic               frame_done,
    input  logic               repeat_hit,
    output logic               frame_valid
);

    logic             repeat_seen;
    logic             wr;
    ir_pkg::ir_byte_t status;

    assign wr = stb && we;  // any write acknowledges the frame

    always_comb begin
        status = '0;
        status[ir_pkg::STATUS_VALID_BIT]  = frame_valid;
        status[ir_pkg::STATUS_REPEAT_BIT] = repeat_seen;
    end

    // set strobes beat a write in the same cycle
    always_ff @(posedge CLK_I or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            frame_valid <= 1'b0;
            repeat_seen <= 1'b0;
        end else begin
            ack <= stb;  // single cycle, no wait states
            if (frame_done) begin
                frame_valid <= 1'b1;
            end else if (wr) begin
                frame_valid <= 1'b0;
            end
            if (repeat_hit) begin
                repeat_seen <= 1'b1;
            end else if (wr) begin
                repeat_seen <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (stb && !we) begin
            case (adr)
                ir_pkg::REG_BYTE0:  dat_r <= frame_valid ? frame[31:24] : '0;
                ir_pkg::REG_BYTE1:  dat_r <= frame_valid ? frame[23:16] : '0;
                ir_pkg::REG_BYTE2:  dat_r <= frame_valid ? frame[15:8] : '0;
                ir_pkg::REG_BYTE3:  dat_r <= frame_valid ? frame[7:0] : '0;
                ir_pkg::REG_STATUS: dat_r <= status;
                default:            dat_r <= '0;  // 5 to 7 unused
            endcase
        end
    end

    // a repeat only arrives while the host still holds a frame
    assert property (@(posedge CLK_I) disable iff (!rst_n)
        repeat_hit |-> frame_valid || $past(wr));

    // write data is ignored but a master still has to drive it
    assert property (@(posedge CLK_I) disable iff (!rst_n)
        wr |-> !$isunknown(dat_w));

endmodule

// ==== verif/ir_decoder_tb.sv ====
module ir_decoder_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_FREQ_HZ = 2_000_000;
    localparam int CYC_PER_US    = CLOCK_FREQ_HZ / 1_000_000;  // two cycles per tick

    // NEC timing in microseconds
    localparam int MARK_US   = 560;
    localparam int LEADER_US = 4500;
    localparam int ZERO_US   = 560;
    localparam int ONE_US    = 1690;
    localparam int REPEAT_US = 2250;
    localparam int GAP_US    = 10_000;  // idle line between frames
    localparam int JIT_US    = 50;

    // worst case length of each kind of burst, used for the run limit
    localparam int FRAME_US  = MARK_US + LEADER_US + JIT_US +
                               32 * (MARK_US + ONE_US + JIT_US) + MARK_US + GAP_US;
    localparam int TRUNC_US  = MARK_US + LEADER_US + JIT_US +
                               16 * (MARK_US + ONE_US + JIT_US) + MARK_US + GAP_US;
    localparam int REP_US    = MARK_US + REPEAT_US + JIT_US + MARK_US + GAP_US;
    localparam int BUS_US    = 500;     // reset and all bus transfers
    localparam int TEST_US   = 11 * FRAME_US + 2 * REP_US + TRUNC_US + BUS_US;
    localparam int CYCLE_LIMIT = TEST_US * CYC_PER_US * 12 / 10;

    localparam int ACK_LIMIT = 8;

    logic       CLK_I = 1'b0;
    logic       rst_n;
    logic [2:0] adr;
    logic [7:0] dat_w;
    logic       stb;
    logic       we;
    logic       ack;
    logic [7:0] dat_r;
    logic       ir_in;

    integer seed;
    int     cycle_count = 0;
    int     ack_cycles  = 0;
    int     xfer_count  = 0;

    // reference model state
    logic [31:0] exp_frame;
    logic        exp_valid;
    logic        exp_repeat;

    ir_decoder_top #(
        .CLOCK_FREQ_HZ (CLOCK_FREQ_HZ)
    ) dut_i (
        .CLK_I (CLK_I),
        .rst_n (rst_n),
        .adr   (adr),
        .dat_w (dat_w),
        .stb   (stb),
        .we    (we),
        .ack   (ack),
        .dat_r (dat_r),
        .ir_in (ir_in)
    );

    always #5 CLK_I = ~CLK_I;

    always @(posedge CLK_I) begin
        cycle_count++;
        if (ack === 1'b1) begin
            ack_cycles++;  // every cycle with ack high
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            abort_run("timeout");
        end
    end

    task automatic abort_run(input string why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped: %s", why);
    endtask

    // hold the line for a number of microseconds, optionally with one flipped cycle
    task automatic hold_line(input logic lvl, input int us, input bit glitch);
        int cycles;
        int i;
        cycles = us * CYC_PER_US;
        for (i = 0; i < cycles; i++) begin
            @(posedge CLK_I);
            #1;
            if (glitch && i == cycles / 2) begin
                ir_in = ~lvl;
            end else begin
                ir_in = lvl;
            end
        end
    endtask

    task automatic send_mark(input bit glitch);
        hold_line(1'b0, MARK_US, glitch);
    endtask

    task automatic send_space(input int nominal_us, input bit glitch);
        int jit;
        jit = $random(seed) % (JIT_US + 1);  // -50 to +50
        hold_line(1'b1, nominal_us + jit, glitch);
    endtask

    // leader, nbits data bits msb first, closing mark, then the idle gap
    task automatic send_frame(input logic [31:0] data, input int nbits, input bit glitch);
        int i;
        send_mark(glitch);
        send_space(LEADER_US, glitch);
        for (i = 0; i < nbits; i++) begin
            send_mark(glitch);
            send_space(data[31 - i] ? ONE_US : ZERO_US, glitch);
        end
        send_mark(glitch);
        hold_line(1'b1, GAP_US, 1'b0);
        if (nbits == 32) begin
            exp_frame = data;
            exp_valid = 1'b1;
        end
    endtask

    task automatic send_repeat();
        send_mark(1'b0);
        send_space(REPEAT_US, 1'b0);
        send_mark(1'b0);
        hold_line(1'b1, GAP_US, 1'b0);
        if (exp_valid) begin
            exp_repeat = 1'b1;  // only counts with a frame pending
        end
    endtask

    task automatic bus_transfer(input logic [2:0] a, input logic w, input logic [7:0] wd,
                                output logic [7:0] rd);
        int waited;
        @(posedge CLK_I);
        #1;
        adr   = a;
        we    = w;
        dat_w = wd;
        stb   = 1'b1;
        @(posedge CLK_I);
        #1;
        stb    = 1'b0;
        we     = 1'b0;
        waited = 0;
        while (ack !== 1'b1 && waited < ACK_LIMIT) begin
            @(posedge CLK_I);
            #1;
            waited++;
        end
        assert (ack === 1'b1) else begin
            $display("no acknowledge for the transfer at address %0d", a);
            abort_run("missing ack");
        end
        rd = dat_r;
        xfer_count++;
        @(posedge CLK_I);
        #1;
        assert (ack === 1'b0) else begin
            $display("acknowledge stayed high for the transfer at address %0d", a);
            abort_run("stretched ack");
        end
    endtask

    task automatic bus_write(input logic [2:0] a);
        logic [7:0] unused;
        bus_transfer(a, 1'b1, $random(seed), unused);
        exp_valid  = 1'b0;
        exp_repeat = 1'b0;
    endtask

    function automatic logic [7:0] expected_byte(input logic [2:0] a);
        logic [7:0] b;
        b = 8'h00;
        case (a)
            3'd0: if (exp_valid) b = exp_frame[31:24];
            3'd1: if (exp_valid) b = exp_frame[23:16];
            3'd2: if (exp_valid) b = exp_frame[15:8];
            3'd3: if (exp_valid) b = exp_frame[7:0];
            3'd4: b = {6'b0, exp_repeat, exp_valid};
            default: b = 8'h00;
        endcase
        return b;
    endfunction

    task automatic check_read(input logic [2:0] a);
        logic [7:0] got;
        logic [7:0] want;
        bus_transfer(a, 1'b0, 8'h00, got);
        want = expected_byte(a);
        assert (got === want) else begin
            $display("[ERROR] %0t: read at address %0d returned %02h, expected %02h",
                     $time, a, got, want);
            abort_run("read mismatch");
        end
    endtask

    // status first, then the four frame bytes
    task automatic check_frame_regs();
        int a;
        check_read(3'd4);
        for (a = 0; a < 4; a++) begin
            check_read(3'(a));
        end
    endtask

    initial begin
        logic [31:0] data;
        int          k;
        seed       = 41;
        rst_n      = 1'b0;
        adr        = '0;
        dat_w      = '0;
        stb        = 1'b0;
        we         = 1'b0;
        ir_in      = 1'b1;  // receiver idles high
        exp_frame  = '0;
        exp_valid  = 1'b0;
        exp_repeat = 1'b0;
        repeat (2) @(posedge CLK_I);
        #1;
        rst_n = 1'b1;

        // nothing received yet
        check_frame_regs();

        for (k = 0; k < 8; k++) begin
            data = $random(seed);
            send_frame(data, 32, 1'b0);
            check_frame_regs();
            bus_write(3'd4);
            check_read(3'd4);
        end

        // repeat with a pending frame, then without
        data = $random(seed);
        send_frame(data, 32, 1'b0);
        send_repeat();
        check_frame_regs();
        bus_write(3'd0);
        send_repeat();
        check_frame_regs();

        // 16 bits then silence must be dropped
        data = $random(seed);
        send_frame(data, 16, 1'b0);
        check_frame_regs();
        data = $random(seed);
        send_frame(data, 32, 1'b0);
        check_frame_regs();
        bus_write(3'd4);

        // one cycle pulses inside every mark and space
        data = $random(seed);
        send_frame(data, 32, 1'b1);
        check_frame_regs();

        // unused addresses with and without a frame
        check_read(3'd5);
        check_read(3'd6);
        check_read(3'd7);
        bus_write(3'd7);
        check_read(3'd5);
        check_read(3'd6);
        check_read(3'd7);
        check_frame_regs();

        assert (ack_cycles == xfer_count) else begin
            $display("[ERROR] %0t: saw %0d ack cycles for %0d transfers",
                     $time, ack_cycles, xfer_count);
            abort_run("ack count mismatch");
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule
